//--- verilog/lorenz_pkg.sv
// ----------------------------------------------------------
// lorenz package
// fixed-point format, Lorenz coefficients, initial state,
// register map and the shared fixed-point multiply
// ----------------------------------------------------------
`default_nettype none

package lorenz_pkg;

  // signed A(9,22) fixed point
  typedef logic signed [31:0] fx_t;

  localparam int FRAC_BITS = 22;

  // coefficients, 8/3 and 0.01 rounded to nearest
  localparam fx_t SIGMA = 32'sh0280_0000;
  localparam fx_t RHO   = 32'sh0700_0000;
  localparam fx_t BETA  = 32'sh00AA_AAAB;
  localparam fx_t H     = 32'sh0000_A3D7;

  // initial state, 1.0 on every axis
  localparam fx_t X0 = 32'sh0040_0000;
  localparam fx_t Y0 = 32'sh0040_0000;
  localparam fx_t Z0 = 32'sh0040_0000;

  // register map, word addresses
  typedef logic [2:0] adr_t;

  localparam adr_t ADR_CTRL  = 3'd0;
  localparam adr_t ADR_X     = 3'd1;
  localparam adr_t ADR_Y     = 3'd2;
  localparam adr_t ADR_Z     = 3'd3;
  localparam adr_t ADR_STEPS = 3'd4;

  // run command: bit 31 requests a reload, low bits carry N
  localparam int CTRL_RELOAD_BIT = 31;

  // full product, rescaled, then wrapped back to 32 bits
  function automatic fx_t fx_mul(fx_t a, fx_t b);
    logic signed [63:0] prod;
    prod = a * b;
    return fx_t'(prod >>> FRAC_BITS);
  endfunction

endpackage

`default_nettype wire

//--- verilog/lorenz_state_if.sv
// ----------------------------------------------------------
// lorenz state interface
// state vector plus load and step controls
// ----------------------------------------------------------
`default_nettype none

interface lorenz_state_if;

  lorenz_pkg::fx_t x;
  lorenz_pkg::fx_t y;
  lorenz_pkg::fx_t z;
  logic            load;
  logic            step_en;

  modport ctrl (output load, output step_en);
  modport x_mp (output x, input y, input z, input load, input step_en);
  modport y_mp (output y, input x, input z, input load, input step_en);
  modport z_mp (output z, input x, input y, input load, input step_en);
  modport rd   (input x, input y, input z);

endinterface

`default_nettype wire

//--- verilog/lorenz_cu.sv
// ----------------------------------------------------------
// lorenz control unit
// sequences the optional reload and N step cycles, counts
// the steps done since the last reload
// ----------------------------------------------------------
`default_nettype none

module lorenz_cu #(
  parameter int STEP_W = 16
) (
  input  wire logic              clk_i,
  input  wire logic              arst_n_i,
  input  wire logic              start_i,
  input  wire logic              reload_i,
  input  wire logic [STEP_W-1:0] steps_i,
  output logic                   busy_o,
  output logic [31:0]            steps_done_o,
  lorenz_state_if.ctrl           st
);

  typedef enum logic [1:0] {S_IDLE, S_LOAD, S_RUN} state_e;

  state_e            state_q;
  logic [STEP_W-1:0] remain_q;
  logic [STEP_W-1:0] done_q;
  logic              load;
  logic              step;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= S_IDLE;
      remain_q <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          // start is only honored here, so commands while busy drop out
          if (start_i) begin
            remain_q <= steps_i;
            if (reload_i) begin
              state_q <= S_LOAD;
            end else if (steps_i != '0) begin
              state_q <= S_RUN;
            end
          end
        end
        S_LOAD: begin
          state_q <= (remain_q != '0) ? S_RUN : S_IDLE;
        end
        S_RUN: begin
          remain_q <= remain_q - 1'b1;
          if (remain_q == STEP_W'(1)) begin
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  assign load = (state_q == S_LOAD);
  assign step = (state_q == S_RUN);

  // steps since last reload
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      done_q <= '0;
    end else if (load) begin
      done_q <= '0;
    end else if (step) begin
      done_q <= done_q + 1'b1;
    end
  end

  assign st.load      = load;
  assign st.step_en   = step;
  assign busy_o       = load | step;
  assign steps_done_o = 32'(done_q);

endmodule

`default_nettype wire

//--- verilog/lorenz_x_path.sv
// ----------------------------------------------------------
// lorenz x datapath
// x register with x += h * sigma * (y - x)
// ----------------------------------------------------------
`default_nettype none

module lorenz_x_path (
  input  wire logic clk_i,
  input  wire logic arst_n_i,
  lorenz_state_if.x_mp st
);

  lorenz_pkg::fx_t x_q;
  lorenz_pkg::fx_t diff;
  lorenz_pkg::fx_t x_next;

  assign diff   = st.y - x_q;
  assign x_next = x_q + lorenz_pkg::fx_mul(lorenz_pkg::fx_mul(diff, lorenz_pkg::SIGMA),
                                           lorenz_pkg::H);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      x_q <= lorenz_pkg::X0;
    end else if (st.load) begin
      x_q <= lorenz_pkg::X0;
    end else if (st.step_en) begin
      x_q <= x_next;
    end
  end

  assign st.x = x_q;

endmodule

`default_nettype wire

//--- verilog/lorenz_y_path.sv
// ----------------------------------------------------------
// lorenz y datapath
// y register with y += h * ((rho - z) * x - y)
// ----------------------------------------------------------
`default_nettype none

module lorenz_y_path (
  input  wire logic clk_i,
  input  wire logic arst_n_i,
  lorenz_state_if.y_mp st
);

  lorenz_pkg::fx_t y_q;
  lorenz_pkg::fx_t rho_z;
  lorenz_pkg::fx_t deriv;
  lorenz_pkg::fx_t y_next;

  assign rho_z  = lorenz_pkg::RHO - st.z;
  assign deriv  = lorenz_pkg::fx_mul(rho_z, st.x) - y_q;
  assign y_next = y_q + lorenz_pkg::fx_mul(deriv, lorenz_pkg::H);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      y_q <= lorenz_pkg::Y0;
    end else if (st.load) begin
      y_q <= lorenz_pkg::Y0;
    end else if (st.step_en) begin
      y_q <= y_next;
    end
  end

  assign st.y = y_q;

endmodule

`default_nettype wire

//--- verilog/lorenz_z_path.sv
// ----------------------------------------------------------
// lorenz z datapath
// z register with z += h * (x * y - beta * z)
// ----------------------------------------------------------
`default_nettype none

module lorenz_z_path (
  input  wire logic clk_i,
  input  wire logic arst_n_i,
  lorenz_state_if.z_mp st
);

  lorenz_pkg::fx_t z_q;
  lorenz_pkg::fx_t xy;
  lorenz_pkg::fx_t bz;
  lorenz_pkg::fx_t z_next;

  assign xy     = lorenz_pkg::fx_mul(st.x, st.y);
  assign bz     = lorenz_pkg::fx_mul(z_q, lorenz_pkg::BETA);
  assign z_next = z_q + lorenz_pkg::fx_mul(xy - bz, lorenz_pkg::H);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      z_q <= lorenz_pkg::Z0;
    end else if (st.load) begin
      z_q <= lorenz_pkg::Z0;
    end else if (st.step_en) begin
      z_q <= z_next;
    end
  end

  assign st.z = z_q;

endmodule

`default_nettype wire

//--- verilog/lorenz_wb_regs.sv
// ----------------------------------------------------------
// lorenz register port
// Wishbone classic slave for run commands, status and state
// ----------------------------------------------------------
`default_nettype none

module lorenz_wb_regs #(
  parameter int STEP_W = 16
) (
  input  wire logic               clk_i,
  input  wire logic               arst_n_i,
  input  wire logic               wb_cyc_i,
  input  wire logic               wb_stb_i,
  input  wire logic               wb_we_i,
  input  wire lorenz_pkg::adr_t   wb_adr_i,
  input  wire logic [31:0]        wb_dat_i,
  output logic [31:0]             wb_dat_o,
  output logic                    wb_ack_o,
  output logic                    start_o,
  output logic                    reload_o,
  output logic [STEP_W-1:0]       steps_o,
  input  wire logic               busy_i,
  input  wire logic [31:0]        steps_done_i,
  lorenz_state_if.rd              st
);

  logic              req;
  logic              ack_q;
  logic              reload_q;
  logic [STEP_W-1:0] steps_q;

  // new request, ack follows on the next clock for one cycle
  assign req = wb_cyc_i & wb_stb_i & ~ack_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  // command fields latched when the write is first seen
  always_ff @(posedge clk_i) begin
    if (req && wb_we_i) begin
      reload_q <= wb_dat_i[lorenz_pkg::CTRL_RELOAD_BIT];
      steps_q  <= wb_dat_i[STEP_W-1:0];
    end
  end

  assign start_o  = ack_q & wb_we_i & (wb_adr_i == lorenz_pkg::ADR_CTRL);
  assign reload_o = reload_q;
  assign steps_o  = steps_q;
  assign wb_ack_o = ack_q;

  always_comb begin
    case (wb_adr_i)
      lorenz_pkg::ADR_CTRL:  wb_dat_o = {31'b0, busy_i};
      lorenz_pkg::ADR_X:     wb_dat_o = st.x;
      lorenz_pkg::ADR_Y:     wb_dat_o = st.y;
      lorenz_pkg::ADR_Z:     wb_dat_o = st.z;
      lorenz_pkg::ADR_STEPS: wb_dat_o = steps_done_i;
      default:               wb_dat_o = 32'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/lorenz_top.sv
// ----------------------------------------------------------
// lorenz top level
// register port, control unit and the x, y, z datapaths
// ----------------------------------------------------------
`default_nettype none

module lorenz_top #(
  parameter int STEP_W = 16
) (
  input  wire logic             clk_i,
  input  wire logic             arst_n_i,
  input  wire logic             wb_cyc_i,
  input  wire logic             wb_stb_i,
  input  wire logic             wb_we_i,
  input  wire lorenz_pkg::adr_t wb_adr_i,
  input  wire logic [31:0]      wb_dat_i,
  output logic [31:0]           wb_dat_o,
  output logic                  wb_ack_o
);

  logic              start;
  logic              reload;
  logic [STEP_W-1:0] steps;
  logic              busy;
  logic [31:0]       steps_done;

  lorenz_state_if st_if ();

  lorenz_wb_regs #(
    .STEP_W(STEP_W)
  ) u_wb_regs (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .start_o      (start),
    .reload_o     (reload),
    .steps_o      (steps),
    .busy_i       (busy),
    .steps_done_i (steps_done),
    .st           (st_if.rd)
  );

  lorenz_cu #(
    .STEP_W(STEP_W)
  ) u_cu (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .start_i      (start),
    .reload_i     (reload),
    .steps_i      (steps),
    .busy_o       (busy),
    .steps_done_o (steps_done),
    .st           (st_if.ctrl)
  );

  // one datapath per axis, coupled through the shared state
  lorenz_x_path u_x_path (.clk_i(clk_i), .arst_n_i(arst_n_i), .st(st_if.x_mp));
  lorenz_y_path u_y_path (.clk_i(clk_i), .arst_n_i(arst_n_i), .st(st_if.y_mp));
  lorenz_z_path u_z_path (.clk_i(clk_i), .arst_n_i(arst_n_i), .st(st_if.z_mp));

endmodule

`default_nettype wire

//--- verif/lorenz_assertions.sv
// ----------------------------------------------------------
// lorenz assertions
// bus protocol and control checks bound into lorenz_top
// ----------------------------------------------------------
`default_nettype none

module lorenz_assertions (
  input wire logic            clk_i,
  input wire logic            arst_n_i,
  input wire logic            cyc_i,
  input wire logic            stb_i,
  input wire logic            ack_i,
  input wire logic            busy_i,
  input wire lorenz_pkg::fx_t x_i,
  input wire lorenz_pkg::fx_t y_i,
  input wire lorenz_pkg::fx_t z_i
);

  // ack only answers a live request
  ack_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ack_i |-> (cyc_i && stb_i))
    else $error("ack high without cyc and stb");

  ack_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ack_i |=> !ack_i)
    else $error("ack held for two cycles");

  // no load or step happens while idle
  state_hold_idle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !busy_i |=> $stable({x_i, y_i, z_i}))
    else $error("state changed while not busy");

  ack_low_after_reset: assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> !ack_i)
    else $error("ack high when leaving reset");

endmodule

bind lorenz_top lorenz_assertions u_assertions (
  .clk_i    (clk_i),
  .arst_n_i (arst_n_i),
  .cyc_i    (wb_cyc_i),
  .stb_i    (wb_stb_i),
  .ack_i    (wb_ack_o),
  .busy_i   (busy),
  .x_i      (st_if.x),
  .y_i      (st_if.y),
  .z_i      (st_if.z)
);

`default_nettype wire

//--- verif/lorenz_tb.sv
// ----------------------------------------------------------
// lorenz testbench
// vector-driven run commands over Wishbone, state checked
// against a fixed-point Euler model and the vector file
// ----------------------------------------------------------
`default_nettype none

module lorenz_tb;

  localparam int RESET_CYCLES = 3;

  logic             clk_i;
  logic             arst_n_i;
  logic             wb_cyc_i;
  logic             wb_stb_i;
  logic             wb_we_i;
  lorenz_pkg::adr_t wb_adr_i;
  logic [31:0]      wb_dat_i;
  logic [31:0]      wb_dat_o;
  logic             wb_ack_o;

  // one entry per vector line
  int              v_mode[$];
  int              v_reload[$];
  int              v_n[$];
  int              v_chk[$];
  logic [31:0]     v_steps[$];
  lorenz_pkg::fx_t v_x[$];
  lorenz_pkg::fx_t v_y[$];
  lorenz_pkg::fx_t v_z[$];

  // model state, plus DUT results of earlier reload runs keyed by N
  lorenz_pkg::fx_t m_x;
  lorenz_pkg::fx_t m_y;
  lorenz_pkg::fx_t m_z;
  lorenz_pkg::fx_t reload_x[int];
  lorenz_pkg::fx_t reload_y[int];
  lorenz_pkg::fx_t reload_z[int];

  int cycle_cnt   = 0;
  int cycle_limit = RESET_CYCLES + 10;
  int busy_cycles = 0;
  int err_cnt     = 0;
  int check_cnt   = 0;
  bit load_ok;

  lorenz_top u_lorenz_top (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: tests still running after %0d cycles", cycle_cnt);
      $display("Verification failed");
      $finish;
    end
  end

  always @(negedge clk_i) begin
    if (u_lorenz_top.busy) begin
      busy_cycles = busy_cycles + 1;
    end
  end

  // product rescaled by 2^22, rounded toward minus infinity, wrapped to 32 bits
  function automatic lorenz_pkg::fx_t mul_fixed(lorenz_pkg::fx_t a, lorenz_pkg::fx_t b);
    longint prod;
    longint scale;
    longint quot;
    scale = longint'(1) << lorenz_pkg::FRAC_BITS;
    prod  = longint'(a) * longint'(b);
    quot  = prod / scale;
    // step down when a negative product got truncated toward zero
    if (prod < 0 && quot * scale != prod) begin
      quot = quot - 1;
    end
    return quot[31:0];
  endfunction

  task automatic model_run(int reload, int n);
    lorenz_pkg::fx_t nx;
    lorenz_pkg::fx_t ny;
    lorenz_pkg::fx_t nz;
    if (reload != 0) begin
      m_x = lorenz_pkg::X0;
      m_y = lorenz_pkg::Y0;
      m_z = lorenz_pkg::Z0;
    end
    repeat (n) begin
      nx = m_x + mul_fixed(mul_fixed(m_y - m_x, lorenz_pkg::SIGMA), lorenz_pkg::H);
      ny = m_y + mul_fixed(mul_fixed(lorenz_pkg::RHO - m_z, m_x) - m_y, lorenz_pkg::H);
      nz = m_z + mul_fixed(mul_fixed(m_x, m_y) - mul_fixed(m_z, lorenz_pkg::BETA),
                           lorenz_pkg::H);
      m_x = nx;
      m_y = ny;
      m_z = nz;
    end
  endtask

  task automatic bus_write(lorenz_pkg::adr_t adr, logic [31:0] data);
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= 1'b1;
    wb_adr_i <= adr;
    wb_dat_i <= data;
    do @(negedge clk_i); while (!wb_ack_o);
    @(posedge clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic bus_read(lorenz_pkg::adr_t adr, output logic [31:0] data);
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= 1'b0;
    wb_adr_i <= adr;
    // read data is valid while ack is high
    do @(negedge clk_i); while (!wb_ack_o);
    data = wb_dat_o;
    @(posedge clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
  endtask

  task automatic wait_idle();
    logic [31:0] status;
    do begin
      bus_read(lorenz_pkg::ADR_CTRL, status);
    end while (status[0]);
  endtask

  task automatic check_fx(string what, lorenz_pkg::fx_t got, lorenz_pkg::fx_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(string what, logic [31:0] got, logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          cnt;
    int          mode;
    int          reload;
    int          n;
    int          chk;
    logic [31:0] steps;
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] z;
    string       line;
    fd = $fopen("verif/lorenz_vectors.txt", "r");
    load_ok = (fd != 0);
    if (load_ok) begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        cnt = $sscanf(line, "%h %h %h %h %h %h %h %h", mode, reload, n, steps, chk, x, y, z);
        // comment and blank lines do not scan
        if (cnt == 8) begin
          v_mode.push_back(mode);
          v_reload.push_back(reload);
          v_n.push_back(n);
          v_steps.push_back(steps);
          v_chk.push_back(chk);
          v_x.push_back(x);
          v_y.push_back(y);
          v_z.push_back(z);
          // run length plus the bus transfers of one test
          cycle_limit += n + 32;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_vector(int idx);
    int              errs_before;
    int              busy_before;
    logic [31:0]     cmd;
    logic [31:0]     rd;
    lorenz_pkg::fx_t dx;
    lorenz_pkg::fx_t dy;
    lorenz_pkg::fx_t dz;
    errs_before = err_cnt;
    busy_before = busy_cycles;
    if (v_mode[idx] != 0) begin
      cmd = 32'(v_n[idx]);
      cmd[lorenz_pkg::CTRL_RELOAD_BIT] = (v_reload[idx] != 0);
      bus_write(lorenz_pkg::ADR_CTRL, cmd);
      if (v_mode[idx] == 2) begin
        // reload and 3 steps, dropped because the run is still going
        bus_write(lorenz_pkg::ADR_CTRL, 32'h8000_0003);
        bus_read(lorenz_pkg::ADR_CTRL, rd);
        check_count("busy during run", rd, 32'd1);
      end
      wait_idle();
      model_run(v_reload[idx], v_n[idx]);
      if (v_n[idx] == 0 && v_reload[idx] == 0) begin
        check_count("busy cycles", 32'(busy_cycles - busy_before), 32'd0);
      end
    end
    bus_read(lorenz_pkg::ADR_X, rd);
    dx = rd;
    bus_read(lorenz_pkg::ADR_Y, rd);
    dy = rd;
    bus_read(lorenz_pkg::ADR_Z, rd);
    dz = rd;
    bus_read(lorenz_pkg::ADR_STEPS, rd);
    check_count("steps done", rd, v_steps[idx]);
    bus_read(lorenz_pkg::ADR_CTRL, rd);
    check_count("status", rd, 32'd0);
    check_fx("x", dx, m_x);
    check_fx("y", dy, m_y);
    check_fx("z", dz, m_z);
    if (v_chk[idx] != 0) begin
      check_fx("x vs vector", dx, v_x[idx]);
      check_fx("y vs vector", dy, v_y[idx]);
      check_fx("z vs vector", dz, v_z[idx]);
    end
    if (v_mode[idx] != 0 && v_reload[idx] != 0) begin
      if (reload_x.exists(v_n[idx])) begin
        check_fx("x vs earlier reload", dx, reload_x[v_n[idx]]);
        check_fx("y vs earlier reload", dy, reload_y[v_n[idx]]);
        check_fx("z vs earlier reload", dz, reload_z[v_n[idx]]);
      end else begin
        reload_x[v_n[idx]] = dx;
        reload_y[v_n[idx]] = dy;
        reload_z[v_n[idx]] = dz;
      end
    end
    if (err_cnt == errs_before) begin
      $display("test %0d mode %0d reload %0d n %0d: ok", idx, v_mode[idx], v_reload[idx],
               v_n[idx]);
    end else begin
      $display("test %0d mode %0d reload %0d n %0d: %0d errors", idx, v_mode[idx],
               v_reload[idx], v_n[idx], err_cnt - errs_before);
    end
  endtask

  initial begin
    arst_n_i = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    m_x = lorenz_pkg::X0;
    m_y = lorenz_pkg::Y0;
    m_z = lorenz_pkg::Z0;
    load_vectors();
    if (!load_ok) begin
      $display("cannot open the vector file verif/lorenz_vectors.txt");
      $display("Verification failed");
    end else begin
      repeat (RESET_CYCLES) @(posedge clk_i);
      arst_n_i <= 1'b1;
      foreach (v_mode[i]) begin
        run_vector(i);
      end
      $display("%0d tests, %0d checks, %0d errors", v_mode.size(), check_cnt, err_cnt);
      if (err_cnt == 0 && v_mode.size() > 0) begin
        $display("Verification passed");
      end else begin
        $display("Verification failed");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/lorenz_vectors.txt
// mode reload n steps chk x y z, all hex
// mode 0 reads only, 1 runs a command, 2 also writes a command while busy; x y z used if chk is 1
0 0 0   0   1 00400000 00400000 00400000
1 1 1   1   1 00400000 0050a3d6 003eeeee
1 0 64  65  0 00000000 00000000 00000000
1 0 c8  12d 0 00000000 00000000 00000000
1 0 96  1c3 0 00000000 00000000 00000000
1 0 0   1c3 0 00000000 00000000 00000000
1 1 1   1   1 00400000 0050a3d6 003eeeee
1 1 80  80  0 00000000 00000000 00000000
1 0 100 180 0 00000000 00000000 00000000
1 1 80  80  0 00000000 00000000 00000000
2 0 c8  148 0 00000000 00000000 00000000
1 0 0   148 0 00000000 00000000 00000000
2 1 40  40  0 00000000 00000000 00000000
1 1 0   0   1 00400000 00400000 00400000
0 0 0   0   1 00400000 00400000 00400000

//--- sim.f
verilog/lorenz_pkg.sv
verilog/lorenz_state_if.sv
verilog/lorenz_cu.sv
verilog/lorenz_x_path.sv
verilog/lorenz_y_path.sv
verilog/lorenz_z_path.sv
verilog/lorenz_wb_regs.sv
verilog/lorenz_top.sv
verif/lorenz_assertions.sv
verif/lorenz_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the Lorenz generator testbench with Verilator.
# Exit status is 0 only when the log holds the pass message.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module lorenz_tb \
  -f sim.f -o lorenz_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "build failed"
  exit 1
fi

./obj_dir/lorenz_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^Verification passed$" "$SIM_LOG"; then
  exit 0
fi
exit 1
